/* common/fpConsts.svh */
`ifndef FP_CONSTS_SVH
`define FP_CONSTS_SVH

// binary32 fields
`define FP_EXP_W 8
`define FP_MAN_W 23
// Significand incl. hidden bit
`define FP_SIG_W 24

// All-ones biased exponent, marks NaN / infinity
`define FP_EXP_MAX 8'hff

// Zero bits appended below the significand for guard/round/sticky
`define FP_EXT_W 8
// Carry + significand + extension
`define FP_SUM_W 33
`define FP_SHIFT_W 5

// Input exception vector width
`define FP_EXC_W 5
// Pipeline registers between input and result
`define FP_PIPE_DEPTH 3

`endif

/* common/fpFormat.sv */
`default_nettype none
`include "fpConsts.svh"

package fpFormat;

	// Sign, exponent, mantissa
	typedef logic [`FP_EXP_W+`FP_MAN_W:0] fpWord;

	typedef logic [`FP_EXP_W-1:0] fpExp;  // Biased exponent
	typedef logic [`FP_MAN_W-1:0] fpMant; // Stored fraction
	typedef logic [`FP_SIG_W-1:0] fpSig;  // Hidden bit + fraction
	typedef logic [`FP_SHIFT_W-1:0] fpShift;

	// [4] any special, [3] aNaN, [2] bNaN, [1] aInf, [0] bInf
	typedef logic [`FP_EXC_W-1:0] fpInExc;

	// IEEE 754 exception flags, no divide-by-zero in an adder
	typedef struct packed {
		logic overflow;
		logic underflow;
		logic invalid;
		logic inexact;
	} fpFlags;

endpackage

`default_nettype wire

/* common/fpPipe.sv */
`default_nettype none
`include "fpConsts.svh"

package fpPipe;

	////////////////////////////////////////////////////////////////////////////
	// Stage 1 -> 2, operands ordered and aligned
	typedef struct packed {
		logic op;                      // 0 add, 1 subtract
		logic signA;
		logic signB;
		logic bLarger;                 // |b| > |a|
		fpFormat::fpExp commonExp;     // Exponent of larger operand
		fpFormat::fpShift alignShift;  // Right shift applied to minSig
		fpFormat::fpMant maxMant;      // Larger fraction, hidden bit implied
		fpFormat::fpInExc inExc;
		fpFormat::fpSig minSig;        // Smaller significand after alignment
	} alignRec;

	////////////////////////////////////////////////////////////////////////////
	// Stage 2 -> 3, raw sum after coarse normalize
	typedef struct packed {
		logic [`FP_SUM_W-1:0] coarseSum;
		fpFormat::fpShift normShift;   // Full left shift, bit 4 already applied
		fpFormat::fpExp commonExp;
		logic signA;
		logic signB;
		logic op;
		logic bLarger;
		fpFormat::fpInExc inExc;
	} sumRec;

	////////////////////////////////////////////////////////////////////////////
	// Stage 3 -> 4, normalized and ready to round
	typedef struct packed {
		fpFormat::fpMant normMant;
		logic [`FP_EXP_W:0] normExp;   // Extra bit catches carry / wrap
		logic zeroSum;
		logic negExp;
		logic guard;
		logic round;
		logic sticky;
		logic signA;
		logic signB;
		logic op;
		logic bLarger;
		fpFormat::fpInExc inExc;
	} normRec;

endpackage

`default_nettype wire

/* fpAdder/fpAlign.sv */
`default_nettype none
`include "fpConsts.svh"

// Stage 1: classify, order by magnitude, align smaller significand
module fpAlign (
	input  fpFormat::fpWord a,
	input  fpFormat::fpWord b,
	input  logic op,
	output fpPipe::alignRec align
);

	localparam int MagW = `FP_EXP_W + `FP_MAN_W; // Magnitude bits, sign excluded

	fpFormat::fpExp expA;
	fpFormat::fpExp expB;
	fpFormat::fpMant mantA;
	fpFormat::fpMant mantB;
	fpFormat::fpExp diffAB;
	fpFormat::fpExp diffBA;
	fpFormat::fpShift shift;
	fpFormat::fpSig lvl0;
	fpFormat::fpSig lvl1;
	fpFormat::fpSig lvl2;
	fpFormat::fpSig lvl3;
	logic aNaN;
	logic bNaN;
	logic aInf;
	logic bInf;
	logic bLarger;

	assign expA = a[`FP_MAN_W +: `FP_EXP_W];
	assign expB = b[`FP_MAN_W +: `FP_EXP_W];
	assign mantA = a[`FP_MAN_W-1:0];
	assign mantB = b[`FP_MAN_W-1:0];

	// All-ones exponent: NaN if fraction nonzero, else infinity
	assign aNaN = (expA == `FP_EXP_MAX) & (|mantA);
	assign bNaN = (expB == `FP_EXP_MAX) & (|mantB);
	assign aInf = (expA == `FP_EXP_MAX) & ~(|mantA);
	assign bInf = (expB == `FP_EXP_MAX) & ~(|mantB);

	assign bLarger = a[MagW-1:0] < b[MagW-1:0]; // Exp and fraction compare as one integer

	assign diffAB = expA - expB;
	assign diffBA = expB - expA;
	assign shift = bLarger ? diffBA[`FP_SHIFT_W-1:0] : diffAB[`FP_SHIFT_W-1:0]; // Wraps past 31

	////////////////////////////////////////////////////////////////////////////
	// Right shifter, bits falling off the bottom are lost
	assign lvl0 = {1'b1, bLarger ? mantA : mantB}; // Smaller one, hidden bit restored
	assign lvl1 = shift[4] ? (lvl0 >> 16) : lvl0;
	assign lvl2 = lvl1 >> {shift[3:2], 2'b00};     // 0/4/8/12
	assign lvl3 = lvl2 >> shift[1:0];              // 0/1/2/3

	always_comb begin
		align.op = op;
		align.signA = a[MagW];
		align.signB = b[MagW];
		align.bLarger = bLarger;
		align.commonExp = bLarger ? expB : expA;
		align.alignShift = shift;
		align.maxMant = bLarger ? mantB : mantA;
		align.inExc = {aNaN | bNaN | aInf | bInf, aNaN, bNaN, aInf, bInf};
		align.minSig = lvl3;
	end

endmodule

`default_nettype wire

/* fpAdder/fpMantSum.sv */
`default_nettype none
`include "fpConsts.svh"

// Stage 2: effective add/sub, leading-one search, 16-bit coarse normalize
module fpMantSum (
	input  fpPipe::alignRec align,
	output fpPipe::sumRec sum
);

	logic effSub;                    // Signs and op disagree
	logic [`FP_SUM_W-1:0] bigVal;
	logic [`FP_SUM_W-1:0] smallVal;
	logic [`FP_SUM_W-1:0] rawSum;
	fpFormat::fpShift normShift;

	assign effSub = align.op ^ align.signA ^ align.signB;

	// Top bit left free for the carry, extension bits zero
	assign bigVal = {1'b0, 1'b1, align.maxMant, {`FP_EXT_W{1'b0}}};
	assign smallVal = {1'b0, align.minSig, {`FP_EXT_W{1'b0}}};

	assign rawSum = effSub ? bigVal - smallVal : bigVal + smallVal;

	////////////////////////////////////////////////////////////////////////////
	// Leading-one detect over carry down to the round position
	always_comb begin
		normShift = fpFormat::fpShift'(`FP_SUM_W - `FP_EXT_W + 1); // Nothing set, zero sum
		for (int i = `FP_EXT_W - 1; i < `FP_SUM_W; i++) begin
			if (rawSum[i]) begin
				normShift = fpFormat::fpShift'(`FP_SUM_W - 1 - i); // Highest set bit wins
			end
		end
	end

	// Larger operand was picked by magnitude, so a subtract never borrows
	always_comb begin
		assert (effSub !== 1'b1 || rawSum[`FP_SUM_W-1] !== 1'b1)
			else $error("fpMantSum: carry set in effective subtract");
	end

	always_comb begin
		sum.coarseSum = normShift[`FP_SHIFT_W-1] ? (rawSum << 16) : rawSum; // Coarse step
		sum.normShift = normShift;
		sum.commonExp = align.commonExp;
		sum.signA = align.signA;
		sum.signB = align.signB;
		sum.op = align.op;
		sum.bLarger = align.bLarger;
		sum.inExc = align.inExc;
	end

endmodule

`default_nettype wire

/* fpAdder/fpNormalize.sv */
`default_nettype none
`include "fpConsts.svh"

// Stage 3: fine left shift, exponent adjust, guard/round/sticky
module fpNormalize (
	input  fpPipe::sumRec sum,
	output fpPipe::normRec norm
);

	logic [`FP_SUM_W-1:0] lvl2;
	logic [`FP_SUM_W-1:0] lvl3;     // Leading one now at the carry position
	logic [`FP_EXP_W:0] expOk;      // Exponent before carry fixup
	logic msbSet;

	////////////////////////////////////////////////////////////////////////////
	// Remaining shift levels, 16 already done upstream
	assign lvl2 = sum.coarseSum << {sum.normShift[3:2], 2'b00}; // 0/4/8/12
	assign lvl3 = lvl2 << sum.normShift[1:0];                   // 0/1/2/3

	assign msbSet = lvl3[`FP_SUM_W-1];

	// Shift counted from the carry bit, so a normal result gets +1 back
	assign expOk = {1'b0, sum.commonExp} - (`FP_EXP_W + 1)'(sum.normShift);

	always_comb begin
		norm.normMant = lvl3[`FP_SUM_W-2 -: `FP_MAN_W]; // Drop the leading one
		norm.normExp = msbSet ? expOk + 1'b1 : expOk;
		norm.zeroSum = ~(|lvl3);
		norm.negExp = expOk[`FP_EXP_W];    // Borrow out of the subtract

		// Bits below the kept fraction
		norm.guard = lvl3[`FP_EXT_W];
		norm.round = lvl3[`FP_EXT_W-1];
		norm.sticky = |lvl3[`FP_EXT_W-2:0];

		// Pass-through fields
		norm.signA = sum.signA;
		norm.signB = sum.signB;
		norm.op = sum.op;
		norm.bLarger = sum.bLarger;
		norm.inExc = sum.inExc;
	end

endmodule

`default_nettype wire

/* fpAdder/fpRound.sv */
`default_nettype none
`include "fpConsts.svh"

// Stage 4: round to nearest even, pack result, raise flags
module fpRound (
	input  fpPipe::normRec norm,
	output fpFormat::fpWord result,
	output fpFormat::fpFlags flags
);

	logic roundUp;
	logic [`FP_MAN_W:0] roundUpMant;  // One extra bit for mantissa overflow
	fpFormat::fpMant roundMant;
	logic roundOf;
	logic [`FP_EXP_W:0] roundExp;
	logic sign;
	logic lost;                       // Any bit below the fraction nonzero
	logic expOver;

	// Above half, or exact tie with odd lsb
	assign roundUp = norm.guard & (norm.round | norm.sticky | norm.normMant[0]);
	assign roundUpMant = {1'b0, norm.normMant} + 1'b1;
	assign roundMant = roundUp ? roundUpMant[`FP_MAN_W-1:0] : norm.normMant;
	assign roundOf = roundUp & roundUpMant[`FP_MAN_W]; // 1.111.. rolled over to 10.000..

	assign roundExp = norm.zeroSum ? '0 : norm.normExp + roundOf;

	// Zero sum sign by operand signs and op, else sign of larger operand
	assign sign = norm.zeroSum ?
		((norm.signA ^ norm.signB) | (norm.signA & norm.signB & ~norm.op)) :
		((~norm.bLarger & norm.signA) |
			((norm.op ^ norm.signB) & (norm.bLarger | norm.signA)));

	assign result = {sign, roundExp[`FP_EXP_W-1:0], roundMant};

	////////////////////////////////////////////////////////////////////////////
	// Exception flags
	assign lost = norm.guard | norm.round | norm.sticky;
	assign expOver = ~norm.negExp &
		(roundExp[`FP_EXP_W] | (roundExp[`FP_EXP_W-1:0] == `FP_EXP_MAX)); // Hit or passed 255

	always_comb begin
		flags.overflow = expOver | norm.inExc[1] | norm.inExc[0]; // Or an infinite input
		flags.underflow = norm.negExp & lost;
		flags.invalid = norm.inExc[3] | norm.inExc[2];            // NaN in
		flags.inexact = lost | flags.overflow | flags.underflow | norm.inExc[4];
	end

	// All-zero sum upstream must leave nothing but the sign
	always_comb begin
		assert (norm.zeroSum !== 1'b1 || result[`FP_EXP_W+`FP_MAN_W-1:0] == '0)
			else $error("fpRound: zero sum with nonzero exponent or fraction");
	end

endmodule

`default_nettype wire

/* fpAdder/fpAdder.sv */
`default_nettype none
`include "fpConsts.svh"

// binary32 add/sub, one op per clock, three cycle latency
module fpAdder (
	input  logic clk,
	input  logic rst,
	input  fpFormat::fpWord a,
	input  fpFormat::fpWord b,
	input  logic op,                   // 0 add, 1 subtract
	output fpFormat::fpWord result,
	output fpFormat::fpFlags flags
);

	fpPipe::alignRec alignNext;
	fpPipe::alignRec alignReg;
	fpPipe::sumRec sumNext;
	fpPipe::sumRec sumReg;
	fpPipe::normRec normNext;
	fpPipe::normRec normReg;

	fpAlign alignStage (
		.a(a),
		.b(b),
		.op(op),
		.align(alignNext)
	);

	fpMantSum sumStage (
		.align(alignReg),
		.sum(sumNext)
	);

	fpNormalize normStage (
		.sum(sumReg),
		.norm(normNext)
	);

	// Output side is combinational off normReg
	fpRound roundStage (
		.norm(normReg),
		.result(result),
		.flags(flags)
	);

	////////////////////////////////////////////////////////////////////////////
	// Pipeline registers, zero record decodes to +0 and no flags
	always_ff @(posedge clk) begin
		if (rst) begin
			alignReg <= '0;
			sumReg <= '0;
			normReg <= '0;
		end else begin
			alignReg <= alignNext;
			sumReg <= sumNext;
			normReg <= normNext;
		end
	end

	// Once the pipe has flushed out of reset the output is fully driven
	resultKnown: assert property (@(posedge clk)
		!rst && !$past(rst) && !$past(rst, 2) |=> !$isunknown(result))
		else $error("fpAdder: unknown result after reset flush");

endmodule

`default_nettype wire

/* testbench/fpAdderModel.svh */
`ifndef FP_ADDER_MODEL_SVH
`define FP_ADDER_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Galois LFSR, x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsrState = 32'hf9b2;

function automatic logic [31:0] lfsrStep(input logic [31:0] s);
	logic lsb;
	lsb = s[0];
	s = s >> 1;
	if (lsb) s = s ^ 32'h8020_0003; // Feedback taps
	return s;
endfunction

// One LFSR step per bit handed out
function automatic logic [31:0] takeBits(input int n);
	logic [31:0] val;
	val = '0;
	for (int i = 0; i < n; i++) begin
		val = {val[30:0], lfsrState[0]};
		lfsrState = lfsrStep(lfsrState);
	end
	return val;
endfunction

function automatic fpFormat::fpWord packWord(input logic s, input int e, input logic [22:0] m);
	return {s, e[7:0], m};
endfunction

////////////////////////////////////////////////////////////////////////////
// Exact integer sum of significands, rounded to 24 bits nearest even
// Returns {flags, word}; only inexact can be set for normal operands
function automatic logic [35:0] modelAdd(input fpFormat::fpWord a, input fpFormat::fpWord b,
		input logic op);
	logic bigIsB;
	logic effSub;
	logic sgn;
	logic [23:0] sigBig;
	logic [23:0] sigSmall;
	int eBig;
	int eSmall;
	int d;
	int p;
	int sh;
	logic [63:0] x;
	logic [63:0] keep;
	logic [63:0] rem;
	logic [63:0] half;
	logic inexact;
	bigIsB = a[30:0] < b[30:0];
	effSub = a[31] ^ b[31] ^ op;
	sigBig = bigIsB ? {1'b1, b[22:0]} : {1'b1, a[22:0]};
	sigSmall = bigIsB ? {1'b1, a[22:0]} : {1'b1, b[22:0]};
	eBig = bigIsB ? int'(b[30:23]) : int'(a[30:23]);
	eSmall = bigIsB ? int'(a[30:23]) : int'(b[30:23]);
	sgn = bigIsB ? b[31] ^ op : a[31];   // Sign follows larger magnitude
	d = eBig - eSmall;
	x = 64'(sigBig) << d;                // lsb weight is that of the smaller operand
	x = effSub ? x - 64'(sigSmall) : x + 64'(sigSmall);
	if (x == 0) return 36'h0;            // Exact cancellation gives +0
	p = 63;
	while (!x[p]) p--;
	inexact = 1'b0;
	if (p > 23) begin
		sh = p - 23;
		keep = x >> sh;
		rem = x & ((64'd1 << sh) - 1);
		half = 64'd1 << (sh - 1);
		inexact = rem != 0;
		if (rem > half || (rem == half && keep[0])) keep = keep + 1;
		if (keep[24]) begin // Rounded up past 24 bits
			keep = keep >> 1;
			p++;
		end
	end else begin
		keep = x << (23 - p);
	end
	return {3'b000, inexact, sgn, 8'(eSmall + p - 23), keep[22:0]};
endfunction

`endif

/* testbench/fpAdderTb.sv */
`default_nettype none
`include "fpConsts.svh"

module fpAdderTb;
	timeunit 1ns;
	timeprecision 100ps;

	`include "fpAdderModel.svh"

	localparam int NumTests = 6;
	localparam int Ops = 64;             // Random operations per random test

	typedef struct packed {
		logic valid;                     // Bubble entries are not checked
		logic [2:0] id;
		fpFormat::fpWord res;
		fpFormat::fpWord resMask;
		fpFormat::fpFlags flg;
		fpFormat::fpFlags flgMask;
	} checkEntry;

	logic clk = 1'b0;
	logic rst = 1'b1;
	fpFormat::fpWord a = '0;
	fpFormat::fpWord b = '0;
	logic op = 1'b0;
	fpFormat::fpWord result;
	fpFormat::fpFlags flags;

	checkEntry pending[$];               // One entry per driven cycle
	checkEntry chk;
	logic resOk;
	logic flgOk;
	int passCnt[NumTests];
	int failCnt[NumTests];
	int totalFail;
	int totalPass;

	fpAdder uut (
		.clk(clk),
		.rst(rst),
		.a(a),
		.b(b),
		.op(op),
		.result(result),
		.flags(flags)
	);

	always #10 clk = ~clk;

	function automatic string testName(input int id);
		case (id)
			0: return "reset flush";
			1: return "random add";
			2: return "cancellation";
			3: return "rounding ties";
			4: return "zero result";
			default: return "special inputs";
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus side
	task automatic issue(input fpFormat::fpWord aV, input fpFormat::fpWord bV, input logic opV,
			input logic valid, input int id, input fpFormat::fpWord expRes,
			input fpFormat::fpWord resMask, input fpFormat::fpFlags expFlg,
			input fpFormat::fpFlags flgMask);
		checkEntry ent;
		@(posedge clk);
		a <= aV;
		b <= bV;
		op <= opV;
		ent = {valid, 3'(id), expRes, resMask, expFlg, flgMask};
		pending.push_back(ent);
	endtask

	task automatic issueModel(input fpFormat::fpWord aV, input fpFormat::fpWord bV,
			input logic opV, input int id);
		logic [35:0] m;
		m = modelAdd(aV, bV, opV);
		issue(aV, bV, opV, 1'b1, id, m[31:0], 32'hffff_ffff, m[35:32], 4'hf);
	endtask

	// Bubbles until the last real entry was checked on the falling edge before
	task automatic drainPipe(input int id);
		repeat (`FP_PIPE_DEPTH + 1) issue('0, '0, 1'b0, 1'b0, 0, '0, '0, '0, '0);
		$display("%-15s %0d checked, %0d failed", testName(id),
			passCnt[id] + failCnt[id], failCnt[id]);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checker, output stable at the falling edge
	always @(negedge clk) begin
		if (pending.size() > `FP_PIPE_DEPTH) begin
			chk = pending.pop_front();
			if (chk.valid) begin
				resOk = ((result ^ chk.res) & chk.resMask) == '0;
				flgOk = ((flags ^ chk.flg) & chk.flgMask) == '0;
				assert (resOk) else
					$display("Fail %s result: expected %h, actual %h",
						testName(chk.id), chk.res, result);
				assert (flgOk) else
					$display("Fail %s flags: expected %b, actual %b",
						testName(chk.id), chk.flg & chk.flgMask, flags & chk.flgMask);
				if (resOk === 1'b1 && flgOk === 1'b1) passCnt[chk.id]++;
				else failCnt[chk.id]++;
			end
		end
	end

	initial begin
		#((NumTests * Ops + 20) * 20);
		$display("Watchdog expired before all tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		logic [22:0] mBig;
		logic [22:0] mSmall;
		fpFormat::fpWord aV;
		fpFormat::fpWord bV;
		fpFormat::fpWord tmp;
		logic s;
		logic sub;
		int eBig;
		int d;
		int k;
		for (int i = 0; i < NumTests; i++) begin
			passCnt[i] = 0;
			failCnt[i] = 0;
		end

		// Reset held 5 edges, output zero until real data reaches normReg
		repeat (4) issue('0, '0, 1'b0, 1'b1, 0, '0, 32'hffff_ffff, '0, 4'hf);
		@(posedge clk);
		rst <= 1'b0;
		pending.push_back('0);
		drainPipe(0);

		// Effective adds, back to back
		for (int i = 0; i < Ops; i++) begin
			eBig = 64 + int'(takeBits(7) % 127);
			d = int'(takeBits(4) % 9);
			mBig = 23'(takeBits(23));
			mSmall = 23'(takeBits(23)) & ~((23'd1 << d) - 1); // Nothing lost in alignment
			s = 1'(takeBits(1));
			sub = 1'(takeBits(1));                           // Opposite signs with subtract
			aV = packWord(s, eBig, mBig);
			bV = packWord(s ^ sub, eBig - d, mSmall);
			if (takeBits(1)) begin
				tmp = aV;
				aV = bV;
				bV = tmp;
			end
			issueModel(aV, bV, sub, 1);
		end
		drainPipe(1);

		// Same exponent, shared top bits, k random low bits
		for (int i = 0; i < Ops; i++) begin
			eBig = 64 + int'(takeBits(7) % 127);
			k = 3 + int'(takeBits(5) % 21);
			mBig = 23'(takeBits(23));
			mSmall = (mBig & ~((23'd1 << k) - 1)) | (23'(takeBits(23)) & ((23'd1 << k) - 1));
			s = 1'(takeBits(1));
			issueModel(packWord(s, eBig, mBig), packWord(s, eBig, mSmall), 1'b1, 2);
		end
		drainPipe(2);

		// Carry pushes one bit into guard
		issueModel(32'h3f80_0001, 32'h3f80_0000, 1'b0, 3); // Tie, even lsb stays
		issueModel(32'h3f80_0003, 32'h3f80_0000, 1'b0, 3); // Tie, odd lsb rounds up
		issueModel(32'h3f80_0002, 32'h3f80_0000, 1'b0, 3); // Exact
		issueModel(32'h3f80_0005, 32'h3f80_0000, 1'b0, 3);
		issueModel(32'h3f80_0003, 32'hbf80_0000, 1'b1, 3);
		issueModel(32'h3fff_ffff, 32'h3f80_0000, 1'b0, 3);
		drainPipe(3);

		issueModel(32'h4049_0fdb, 32'h4049_0fdb, 1'b1, 4);
		issueModel(32'hc120_0000, 32'hc120_0000, 1'b1, 4);
		issueModel(32'h3f80_0001, 32'h3f80_0001, 1'b1, 4);
		issueModel(32'hc0a0_0000, 32'hc0a0_0000, 1'b0, 4); // Negative stays negative
		drainPipe(4);

		// Flags only, flag order overflow/underflow/invalid/inexact
		issue(32'h7fc0_0000, 32'h3f80_0000, 1'b0, 1'b1, 5, '0, '0, 4'b0011, 4'b0011);
		issue(32'h3f80_0000, 32'h7fa0_0000, 1'b1, 1'b1, 5, '0, '0, 4'b0011, 4'b0011);
		issue(32'h7f80_0000, 32'h3f80_0000, 1'b0, 1'b1, 5, '0, '0, 4'b1001, 4'b1011);
		issue(32'hff80_0000, 32'h4000_0000, 1'b1, 1'b1, 5, '0, '0, 4'b1001, 4'b1011);
		issue(32'h7f7f_ffff, 32'h7f7f_ffff, 1'b0, 1'b1, 5, '0, '0, 4'b1001, 4'hf);
		issue(32'h7f00_0000, 32'h7f00_0000, 1'b0, 1'b1, 5, '0, '0, 4'b1001, 4'hf);
		drainPipe(5);

		totalFail = 0;
		totalPass = 0;
		for (int i = 0; i < NumTests; i++) begin
			totalFail += failCnt[i];
			totalPass += passCnt[i];
		end
		$display("%0d tests, %0d checks passed, %0d failed", NumTests, totalPass, totalFail);
		if (totalFail == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
+incdir+testbench
common/fpFormat.sv
common/fpPipe.sv
fpAdder/fpAlign.sv
fpAdder/fpMantSum.sv
fpAdder/fpNormalize.sv
fpAdder/fpRound.sv
fpAdder/fpAdder.sv
testbench/fpAdderTb.sv

/* run.sh */
#!/bin/sh
# Build and run the fpAdder testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module fpAdderTb -f vlog.f -o fpAdderSim

./obj_dir/fpAdderSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	exit 0
fi
exit 1
